/* rtl/asp_mem_pkg.sv */
// local-memory write path definitions
// widths and vector types shared by the kernel and memory sides of the shim
package asp_mem_pkg;

  // kernel byte address and memory word address
  localparam int KMEM_ADDR_WIDTH  = 32;
  localparam int WORD_BYTE_OFFSET = 6;   // 64-byte memory word
  localparam int EMIF_ADDR_WIDTH  = KMEM_ADDR_WIDTH - WORD_BYTE_OFFSET;

  // write payload
  localparam int DATA_WIDTH  = 512;
  localparam int BE_WIDTH    = 64;
  localparam int BURST_WIDTH = 5;        // burst counts 1..16

  // bursts written but not yet acknowledged by memory
  localparam int MAX_OUTSTANDING = 4;

  typedef logic [KMEM_ADDR_WIDTH-1:0] kmem_addr_t;
  typedef logic [EMIF_ADDR_WIDTH-1:0] emif_addr_t;
  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [BE_WIDTH-1:0]        be_t;
  typedef logic [BURST_WIDTH-1:0]     burst_t;

  // write burst tracking
  typedef enum logic {
    IDLE,
    IN_BURST
  } burst_state_t;

endpackage

/* rtl/asp_irq_pkg.sv */
// interrupt and debug counter definitions
// line positions, synchronizer depth and counter width
package asp_irq_pkg;

  localparam int NUM_IRQ_LINES = 4;

  // line positions in the interrupt vector
  localparam int KERNEL_IRQ_BIT  = 0;
  localparam int DMA_H2F_IRQ_BIT = 1;
  localparam int DMA_F2H_IRQ_BIT = 2;  // line 3 unused

  // flops on the kernel interrupt
  localparam int IRQ_SYNC_STAGES = 3;

  // debug traffic counters
  localparam int CNT_WIDTH = 32;

  typedef logic [NUM_IRQ_LINES-1:0] irq_vec_t;
  typedef logic [CNT_WIDTH-1:0]     count_t;

endpackage

/* rtl/wr_burst_fsm.sv */
// write burst tracker
// knows whether a burst is open, flags its first beat and its completion
`timescale 1ns/1ps

module wr_burst_fsm (
  input  logic                clk,
  input  logic                reset,
  input  logic                accepted,
  input  asp_mem_pkg::burst_t kmem_burstcount,
  input  logic                last_beat,
  output logic                first_beat,
  output logic                burst_done
);

  asp_mem_pkg::burst_state_t state;
  asp_mem_pkg::burst_state_t state_next;

  assign first_beat = (state == asp_mem_pkg::IDLE);
  assign burst_done = accepted && last_beat;  // completes on the accepted last beat

  always_comb
  begin
    state_next = state;
    if (accepted)
    begin
      if (last_beat)
        state_next = asp_mem_pkg::IDLE;
      else
        state_next = asp_mem_pkg::IN_BURST;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= asp_mem_pkg::IDLE;
    else
      state <= state_next;
  end

  // a burst can only close on a beat that the bridge actually took
  assert property (@(posedge clk) disable iff (reset)
    burst_done |-> accepted);

  // kernel must open every burst with a legal length
  assert property (@(posedge clk) disable iff (reset)
    (accepted && first_beat) |->
      (kmem_burstcount != '0 && kmem_burstcount <= asp_mem_pkg::burst_t'(16)));

endmodule

/* rtl/burst_beat_counter.sv */
// beat counter for the open write burst
// loads on the first beat, counts down and flags the last beat
`timescale 1ns/1ps

module burst_beat_counter (
  input  logic                clk,
  input  logic                reset,
  input  logic                accepted,
  input  logic                first_beat,
  input  asp_mem_pkg::burst_t kmem_burstcount,
  output logic                last_beat
);

  asp_mem_pkg::burst_t remaining;  // beats still to come after the current one

  // burst count only valid on the first beat
  assign last_beat = first_beat ? (kmem_burstcount == asp_mem_pkg::burst_t'(1))
                                : (remaining == asp_mem_pkg::burst_t'(1));

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      remaining <= '0;
    end
    else if (accepted)
    begin
      if (first_beat)
        remaining <= kmem_burstcount - asp_mem_pkg::burst_t'(1);
      else
        remaining <= remaining - asp_mem_pkg::burst_t'(1);
    end
  end

  // mid-burst beats always have something left to count
  assert property (@(posedge clk) disable iff (reset)
    (accepted && !first_beat) |-> (remaining != '0));

endmodule

/* rtl/local_mem_bridge.sv */
// local-memory write bridge
// forwards kernel writes, tracks outstanding bursts and returns write acks
`timescale 1ns/1ps

module local_mem_bridge (
  input  logic                    clk,
  input  logic                    reset,

  input  logic                    kmem_write,
  input  asp_mem_pkg::kmem_addr_t kmem_address,
  input  asp_mem_pkg::data_t      kmem_writedata,
  input  asp_mem_pkg::be_t        kmem_byteenable,
  input  asp_mem_pkg::burst_t     kmem_burstcount,
  output logic                    kmem_waitrequest,
  output logic                    kmem_writeack,

  output logic                    emif_write,
  output asp_mem_pkg::emif_addr_t emif_address,
  output asp_mem_pkg::data_t      emif_writedata,
  output asp_mem_pkg::be_t        emif_byteenable,
  output asp_mem_pkg::burst_t     emif_burstcount,
  input  logic                    emif_waitrequest,
  input  logic                    emif_writeresponsevalid,

  input  logic                    burst_done,
  output logic                    accepted,
  output logic                    ack_pulse
);

  localparam int OUTST_WIDTH = $clog2(asp_mem_pkg::MAX_OUTSTANDING + 1);

  logic [OUTST_WIDTH-1:0] outstanding;  // bursts awaiting a response
  logic                   full;

  // straight through, byte address becomes word address
  assign emif_write      = kmem_write;
  assign emif_address    = kmem_address[asp_mem_pkg::KMEM_ADDR_WIDTH-1:
                                        asp_mem_pkg::WORD_BYTE_OFFSET];
  assign emif_writedata  = kmem_writedata;
  assign emif_byteenable = kmem_byteenable;
  assign emif_burstcount = kmem_burstcount;

  // a response in this cycle frees a slot right away
  assign full = (outstanding == OUTST_WIDTH'(asp_mem_pkg::MAX_OUTSTANDING))
                && !emif_writeresponsevalid;

  assign kmem_waitrequest = emif_waitrequest || full;
  assign accepted         = kmem_write && !kmem_waitrequest;
  assign ack_pulse        = kmem_writeack;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      outstanding   <= '0;
      kmem_writeack <= 1'b0;
    end
    else
    begin
      kmem_writeack <= emif_writeresponsevalid;  // one ack per response, a cycle later
      case ({burst_done, emif_writeresponsevalid})
        2'b10:   outstanding <= outstanding + OUTST_WIDTH'(1);
        2'b01:   outstanding <= outstanding - OUTST_WIDTH'(1);
        default: outstanding <= outstanding;     // both or neither
      endcase
    end
  end

  // memory answers only bursts that were completed earlier
  assert property (@(posedge clk) disable iff (reset)
    emif_writeresponsevalid |-> (outstanding != '0));

  assert property (@(posedge clk) disable iff (reset)
    outstanding <= OUTST_WIDTH'(asp_mem_pkg::MAX_OUTSTANDING));

endmodule

/* rtl/traffic_counters.sv */
// debug traffic counters
// accepted bursts, accepted beats and write acks, wrapping at full width
`timescale 1ns/1ps

module traffic_counters (
  input  logic                clk,
  input  logic                reset,
  input  logic                accepted,
  input  logic                burst_done,
  input  logic                ack_pulse,
  output asp_irq_pkg::count_t burst_count,
  output asp_irq_pkg::count_t beat_count,
  output asp_irq_pkg::count_t ack_count
);

  localparam int NUM_CNT   = 3;
  localparam int BURST_IDX = 0;
  localparam int BEAT_IDX  = 1;
  localparam int ACK_IDX   = 2;

  logic [NUM_CNT-1:0]  inc;
  asp_irq_pkg::count_t cnt [NUM_CNT];

  // event per counter slot
  assign inc[BURST_IDX] = burst_done;
  assign inc[BEAT_IDX]  = accepted;
  assign inc[ACK_IDX]   = ack_pulse;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < NUM_CNT; i++)
        cnt[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < NUM_CNT; i++)
      begin
        if (inc[i])
          cnt[i] <= cnt[i] + asp_irq_pkg::count_t'(1);  // wraps
      end
    end
  end

  assign burst_count = cnt[BURST_IDX];
  assign beat_count  = cnt[BEAT_IDX];
  assign ack_count   = cnt[ACK_IDX];

  // acks can never run ahead of the bursts that caused them
  assert property (@(posedge clk) disable iff (reset)
    (burst_count == '0) |-> (ack_count == '0));

endmodule

/* rtl/irq_aggregator.sv */
// interrupt aggregator
// syncs the kernel interrupt and builds the interrupt vector
`timescale 1ns/1ps

module irq_aggregator (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  kernel_irq,
  input  logic                  dma_irq_h2f,
  input  logic                  dma_irq_f2h,
  output asp_irq_pkg::irq_vec_t irq
);

  logic [asp_irq_pkg::IRQ_SYNC_STAGES-1:0] kernel_irq_sync;

  always_ff @(posedge clk)
  begin
    if (reset)
      kernel_irq_sync <= '0;
    else
      kernel_irq_sync <= {kernel_irq_sync[asp_irq_pkg::IRQ_SYNC_STAGES-2:0], kernel_irq};
  end

  always_comb
  begin
    irq = '0;  // unused lines stay low
    irq[asp_irq_pkg::KERNEL_IRQ_BIT]  = kernel_irq_sync[asp_irq_pkg::IRQ_SYNC_STAGES-1];
    irq[asp_irq_pkg::DMA_H2F_IRQ_BIT] = dma_irq_h2f;
    irq[asp_irq_pkg::DMA_F2H_IRQ_BIT] = dma_irq_f2h;
  end

endmodule

/* rtl/asp_shim.sv */
// kernel-side memory and interrupt shim
// write path to local memory, write acks, interrupt vector and debug counters
`timescale 1ns/1ps

module asp_shim (
  input  logic                    clk,
  input  logic                    reset,

  // kernel write channel
  input  logic                    kmem_write,
  input  asp_mem_pkg::kmem_addr_t kmem_address,
  input  asp_mem_pkg::data_t      kmem_writedata,
  input  asp_mem_pkg::be_t        kmem_byteenable,
  input  asp_mem_pkg::burst_t     kmem_burstcount,
  output logic                    kmem_waitrequest,
  output logic                    kmem_writeack,

  // memory controller write channel
  output logic                    emif_write,
  output asp_mem_pkg::emif_addr_t emif_address,
  output asp_mem_pkg::data_t      emif_writedata,
  output asp_mem_pkg::be_t        emif_byteenable,
  output asp_mem_pkg::burst_t     emif_burstcount,
  input  logic                    emif_waitrequest,
  input  logic                    emif_writeresponsevalid,

  // interrupts
  input  logic                    kernel_irq,
  input  logic                    dma_irq_h2f,
  input  logic                    dma_irq_f2h,
  output asp_irq_pkg::irq_vec_t   irq,

  // debug counters
  output asp_irq_pkg::count_t     burst_count,
  output asp_irq_pkg::count_t     beat_count,
  output asp_irq_pkg::count_t     ack_count
);

  logic accepted;    // beat taken this cycle
  logic first_beat;
  logic last_beat;
  logic burst_done;
  logic ack_pulse;

  local_mem_bridge i_bridge (
    .clk                     (clk),
    .reset                   (reset),
    .kmem_write              (kmem_write),
    .kmem_address            (kmem_address),
    .kmem_writedata          (kmem_writedata),
    .kmem_byteenable         (kmem_byteenable),
    .kmem_burstcount         (kmem_burstcount),
    .kmem_waitrequest        (kmem_waitrequest),
    .kmem_writeack           (kmem_writeack),
    .emif_write              (emif_write),
    .emif_address            (emif_address),
    .emif_writedata          (emif_writedata),
    .emif_byteenable         (emif_byteenable),
    .emif_burstcount         (emif_burstcount),
    .emif_waitrequest        (emif_waitrequest),
    .emif_writeresponsevalid (emif_writeresponsevalid),
    .burst_done              (burst_done),
    .accepted                (accepted),
    .ack_pulse               (ack_pulse)
  );

  wr_burst_fsm i_burst_fsm (
    .clk             (clk),
    .reset           (reset),
    .accepted        (accepted),
    .kmem_burstcount (kmem_burstcount),
    .last_beat       (last_beat),
    .first_beat      (first_beat),
    .burst_done      (burst_done)
  );

  burst_beat_counter i_beat_counter (
    .clk             (clk),
    .reset           (reset),
    .accepted        (accepted),
    .first_beat      (first_beat),
    .kmem_burstcount (kmem_burstcount),
    .last_beat       (last_beat)
  );

  traffic_counters i_counters (
    .clk         (clk),
    .reset       (reset),
    .accepted    (accepted),
    .burst_done  (burst_done),
    .ack_pulse   (ack_pulse),
    .burst_count (burst_count),
    .beat_count  (beat_count),
    .ack_count   (ack_count)
  );

  irq_aggregator i_irq (
    .clk         (clk),
    .reset       (reset),
    .kernel_irq  (kernel_irq),
    .dma_irq_h2f (dma_irq_h2f),
    .dma_irq_f2h (dma_irq_f2h),
    .irq         (irq)
  );

endmodule

/* testbench/tb_asp_shim.sv */
// testbench for the kernel-side memory and interrupt shim
// random kernel bursts against a memory model, checked by assertions
`timescale 1ns/1ps

module tb_asp_shim;

  localparam int MAX_CYCLES = 4000;  // 28 bursts of up to 16 beats plus stalls and delays
  localparam int NUM_BURSTS = 20;

  bit                      clk;
  logic                    reset;
  logic                    kmem_write;
  asp_mem_pkg::kmem_addr_t kmem_address;
  asp_mem_pkg::data_t      kmem_writedata;
  asp_mem_pkg::be_t        kmem_byteenable;
  asp_mem_pkg::burst_t     kmem_burstcount;
  logic                    kmem_waitrequest;
  logic                    kmem_writeack;
  logic                    emif_write;
  asp_mem_pkg::emif_addr_t emif_address;
  asp_mem_pkg::data_t      emif_writedata;
  asp_mem_pkg::be_t        emif_byteenable;
  asp_mem_pkg::burst_t     emif_burstcount;
  logic                    emif_waitrequest;
  logic                    emif_writeresponsevalid;
  logic                    kernel_irq;
  logic                    dma_irq_h2f;
  logic                    dma_irq_f2h;
  asp_irq_pkg::irq_vec_t   irq;
  asp_irq_pkg::count_t     burst_count;
  asp_irq_pkg::count_t     beat_count;
  asp_irq_pkg::count_t     ack_count;

  int                  cycle;
  int                  exp_outst;      // bursts done but not yet answered
  int                  beats_left;
  int                  beats_after;
  logic                burst_end;
  logic                rsp_d;
  logic                exp_wait;
  logic                beat_taken;     // handshake seen at the last edge
  asp_irq_pkg::count_t exp_bursts;
  asp_irq_pkg::count_t exp_beats;
  asp_irq_pkg::count_t exp_acks;

  int         done_q[$];     // cycles where a burst completed
  int         resp_due[$];   // in-order response times
  int         last_due;
  int         due;
  int         release_cycle; // responses held back before this cycle
  int         resp_sent;
  int         errors;
  int         tests;
  int         errors_before;
  int         sent_bursts;
  int         sent_beats;
  int         first_accept_cycle;
  logic [1:0] dma_bits;

  asp_shim i_dut (.*);

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // expected back-pressure, from memory stall and the outstanding limit
  assign exp_wait = emif_waitrequest ||
                    (exp_outst == asp_mem_pkg::MAX_OUTSTANDING && !emif_writeresponsevalid);

  always @(posedge clk)
  begin
    beat_taken <= kmem_write && !kmem_waitrequest;
    if (reset)
    begin
      exp_outst  <= 0;
      beats_left <= 0;
      rsp_d      <= 1'b0;
      exp_bursts <= '0;
      exp_beats  <= '0;
      exp_acks   <= '0;
    end
    else
    begin
      burst_end = 1'b0;
      rsp_d <= emif_writeresponsevalid;
      if (rsp_d)
        exp_acks <= exp_acks + 1;  // ack one cycle after the response
      if (kmem_write && !exp_wait)
      begin
        exp_beats <= exp_beats + 1;
        beats_after = (beats_left == 0) ? int'(kmem_burstcount) - 1 : beats_left - 1;
        beats_left <= beats_after;
        burst_end = (beats_after == 0);
        if (burst_end)
        begin
          exp_bursts <= exp_bursts + 1;
          done_q.push_back(cycle);
        end
      end
      exp_outst <= exp_outst + int'(burst_end) - int'(emif_writeresponsevalid);
    end
  end

  // memory model, random stalls and delayed in-order responses
  always @(negedge clk)
  begin
    emif_waitrequest = ($urandom % 4) == 0;
    while (done_q.size() > 0)
    begin
      due = done_q.pop_front() + 2 + int'($urandom % 10);
      if (due <= last_due)
        due = last_due + 1;
      last_due = due;
      resp_due.push_back(due);
    end
    emif_writeresponsevalid = 1'b0;
    if (resp_due.size() > 0 && cycle >= resp_due[0] && cycle >= release_cycle)
    begin
      emif_writeresponsevalid = 1'b1;
      void'(resp_due.pop_front());
      resp_sent++;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    irq[asp_irq_pkg::KERNEL_IRQ_BIT] == $past(kernel_irq, asp_irq_pkg::IRQ_SYNC_STAGES))
    else report_mismatch("irq[0]", $sampled(irq[0]), !$sampled(irq[0]));
  assert property (@(posedge clk) disable iff (reset)
    irq[asp_irq_pkg::DMA_H2F_IRQ_BIT] == dma_irq_h2f)
    else report_mismatch("irq[1]", $sampled(irq[1]), $sampled(dma_irq_h2f));
  assert property (@(posedge clk) disable iff (reset)
    irq[asp_irq_pkg::DMA_F2H_IRQ_BIT] == dma_irq_f2h)
    else report_mismatch("irq[2]", $sampled(irq[2]), $sampled(dma_irq_f2h));
  assert property (@(posedge clk) disable iff (reset) irq[3] == 1'b0)
    else report_mismatch("irq[3]", $sampled(irq[3]), 0);
  assert property (@(posedge clk) disable iff (reset) emif_write == kmem_write)
    else report_mismatch("emif_write", $sampled(emif_write), $sampled(kmem_write));
  assert property (@(posedge clk) disable iff (reset)
    emif_address == asp_mem_pkg::emif_addr_t'(kmem_address >> asp_mem_pkg::WORD_BYTE_OFFSET))
    else report_mismatch("emif_address", $sampled(emif_address),
                         $sampled(kmem_address) >> asp_mem_pkg::WORD_BYTE_OFFSET);
  assert property (@(posedge clk) disable iff (reset) emif_writedata == kmem_writedata)
    else report_mismatch("emif_writedata", $sampled(emif_writedata), $sampled(kmem_writedata));
  assert property (@(posedge clk) disable iff (reset) emif_byteenable == kmem_byteenable)
    else report_mismatch("emif_byteenable", $sampled(emif_byteenable),
                         $sampled(kmem_byteenable));
  assert property (@(posedge clk) disable iff (reset) emif_burstcount == kmem_burstcount)
    else report_mismatch("emif_burstcount", $sampled(emif_burstcount),
                         $sampled(kmem_burstcount));
  assert property (@(posedge clk) disable iff (reset) kmem_waitrequest == exp_wait)
    else report_mismatch("kmem_waitrequest", $sampled(kmem_waitrequest), $sampled(exp_wait));
  assert property (@(posedge clk) disable iff (reset)
    kmem_writeack == $past(emif_writeresponsevalid))
    else report_mismatch("kmem_writeack", $sampled(kmem_writeack), !$sampled(kmem_writeack));
  assert property (@(posedge clk) disable iff (reset) kmem_waitrequest |=> $stable(beat_count))
    else report_problem("a beat was counted while kmem_waitrequest was high");
  assert property (@(posedge clk) disable iff (reset) burst_count == exp_bursts)
    else report_mismatch("burst_count", $sampled(burst_count), $sampled(exp_bursts));
  assert property (@(posedge clk) disable iff (reset) beat_count == exp_beats)
    else report_mismatch("beat_count", $sampled(beat_count), $sampled(exp_beats));
  assert property (@(posedge clk) disable iff (reset) ack_count == exp_acks)
    else report_mismatch("ack_count", $sampled(ack_count), $sampled(exp_acks));

  task automatic report_mismatch(input string name, input logic [511:0] got,
                                 input logic [511:0] exp);
    errors++;
    $display("Fail at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("Error at %0d ns: %s", $time, what);
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %-14s %s", tests, name, (errors == errors_before) ? "ok" : "FAILED");
    errors_before = errors;
  endtask

  // resume just after the edge, once its flops have settled
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic asp_mem_pkg::data_t random_data();
    asp_mem_pkg::data_t d;
    for (int i = 0; i < asp_mem_pkg::DATA_WIDTH / 32; i++)
      d[i*32 +: 32] = $urandom;
    return d;
  endfunction

  // one burst, fields held while kmem_waitrequest is high
  task automatic send_burst(input int len);
    asp_mem_pkg::kmem_addr_t addr;
    asp_mem_pkg::data_t      data;
    asp_mem_pkg::be_t        be;
    addr = $urandom;
    for (int i = 0; i < len; i++)
    begin
      data = random_data();
      be   = {$urandom, $urandom};
      @(negedge clk);
      kmem_write      = 1'b1;
      kmem_address    = addr;
      kmem_burstcount = asp_mem_pkg::burst_t'(len);
      kmem_writedata  = data;
      kmem_byteenable = be;
      do
        next_cycle();
      while (!beat_taken);
      if (i == 0)
        first_accept_cycle = cycle;
    end
    @(negedge clk);
    kmem_write = 1'b0;
    next_cycle();
    sent_bursts++;
    sent_beats += len;
  endtask

  task automatic wait_for_responses();
    while (done_q.size() > 0 || resp_due.size() > 0 || exp_outst != 0)
      next_cycle();
    repeat (3) next_cycle();  // ack and counter trail the last response
  endtask

  initial
  begin
    void'($urandom(66038));
    reset = 1'b1;
    kmem_write = 1'b0;
    kmem_address = '0;
    kmem_writedata = '0;
    kmem_byteenable = '0;
    kmem_burstcount = '0;
    emif_waitrequest = 1'b0;
    emif_writeresponsevalid = 1'b0;
    kernel_irq = 1'b0;
    dma_irq_h2f = 1'b0;
    dma_irq_f2h = 1'b0;
    {last_due, release_cycle, resp_sent, errors, tests, errors_before} = '0;
    {sent_bursts, sent_beats, first_accept_cycle} = '0;

    repeat (2) next_cycle();
    @(negedge clk);
    reset = 1'b0;
    next_cycle();
    assert (irq == '0) else report_mismatch("irq", irq, 0);
    assert (kmem_writeack == 1'b0) else report_mismatch("kmem_writeack", kmem_writeack, 0);
    assert (burst_count == '0) else report_mismatch("burst_count", burst_count, 0);
    assert (beat_count == '0) else report_mismatch("beat_count", beat_count, 0);
    assert (ack_count == '0) else report_mismatch("ack_count", ack_count, 0);
    finish_test("reset");

    for (int i = 0; i < 12; i++)
    begin
      dma_bits = 2'($urandom);
      @(negedge clk);
      kernel_irq  = (i < 6);  // one rise, one fall
      dma_irq_h2f = dma_bits[0];
      dma_irq_f2h = dma_bits[1];
      next_cycle();
    end
    repeat (4) next_cycle();
    finish_test("interrupts");

    for (int i = 1; i <= 3; i++)
      send_burst(i);
    finish_test("pass-through");

    repeat (NUM_BURSTS) send_burst(1 + int'($urandom % 16));
    wait_for_responses();
    finish_test("write acks");

    release_cycle = MAX_CYCLES;  // hold every response
    repeat (asp_mem_pkg::MAX_OUTSTANDING) send_burst(1 + int'($urandom % 4));
    assert (exp_outst == asp_mem_pkg::MAX_OUTSTANDING)
      else report_problem("outstanding limit was not reached before the stall");
    release_cycle = cycle + 12;
    send_burst(2);
    assert (first_accept_cycle > release_cycle)
      else report_problem("a write was accepted while four bursts were outstanding");
    wait_for_responses();
    finish_test("back-pressure");

    assert (burst_count == sent_bursts) else report_mismatch("burst_count", burst_count, sent_bursts);
    assert (beat_count == sent_beats) else report_mismatch("beat_count", beat_count, sent_beats);
    assert (ack_count == resp_sent) else report_mismatch("ack_count", ack_count, resp_sent);
    finish_test("counters");

    $display("%0d tests run, %0d checks failed", tests, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* src.f */
rtl/asp_mem_pkg.sv
rtl/asp_irq_pkg.sv
rtl/wr_burst_fsm.sv
rtl/burst_beat_counter.sv
rtl/local_mem_bridge.sv
rtl/traffic_counters.sv
rtl/irq_aggregator.sv
rtl/asp_shim.sv
testbench/tb_asp_shim.sv

/* run.sh */
#!/bin/sh
# build and run the shim testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_asp_shim -f src.f -Mdir obj_dir

out=$(./obj_dir/Vtb_asp_shim)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
